//--- fir_pkg.sv
// FIR filter shared definitions
// Widths, AHB-Lite register map, bus codes and the types passed between blocks

package fir_pkg;

  // ****************************************
  // Widths
  // ****************************************
  localparam int NUM_TAPS = 4;
  localparam int DATA_W   = 16;
  localparam int ADDR_W   = 4;
  localparam int BYTE_W   = 8;
  // Product and partial sum, two guard bits for four taps
  localparam int PROD_W   = 2 * DATA_W;
  localparam int ACC_W    = PROD_W + $clog2(NUM_TAPS);

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [PROD_W-1:0] prod_t;
  typedef logic [ACC_W-1:0]  acc_t;

  // ****************************************
  // Register map, byte addresses
  // ****************************************
  localparam addr_t ADDR_STATUS    = addr_t'(0);
  localparam addr_t ADDR_RESULT    = addr_t'(2);
  localparam addr_t ADDR_SAMPLE    = addr_t'(4);
  localparam addr_t ADDR_COEF_BASE = addr_t'(6);
  // First address past F3, so 14 and 15 stay unmapped
  localparam addr_t ADDR_COEF_END  = addr_t'(6 + 2 * NUM_TAPS);

  // Status word bits
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_ERR_BIT  = 8;

  // Bus codes
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic       HSIZE_BYTE    = 1'b0;
  localparam logic       HSIZE_HALF    = 1'b1;

  // Address-phase controls from the master
  typedef struct packed {
    logic       hsel;
    logic [1:0] htrans;
    addr_t      haddr;
    logic       hsize;
    logic       hwrite;
  } ahb_req_t;

  // New sample strobe with its value
  typedef struct packed {
    logic  valid;
    word_t data;
  } sample_beat_t;

  typedef word_t [NUM_TAPS-1:0] coef_bank_t;

endpackage

//--- fir_tap.sv
// One stage of the transposed FIR pipeline
// Adds sample times coefficient to the partial sum from the next stage.
// The output stage presents its sum combinationally for the result register

`timescale 1ns/1ps

module fir_tap #(
  parameter bit COMB_OUT = 1'b0
) (
  input  logic                  tb_clk,
  input  logic                  rst_n,
  input  fir_pkg::sample_beat_t sample,
  input  fir_pkg::word_t        coef,
  input  fir_pkg::acc_t         acc_in,
  output fir_pkg::acc_t         acc_out
);
  import fir_pkg::*;

  prod_t prod;
  acc_t  sum;

  // Unsigned 16x16 multiply, then widen into the partial-sum range
  assign prod = sample.data * coef;
  assign sum  = acc_in + acc_t'(prod);

  generate
    if (COMB_OUT) begin : g_comb
      // Output stage, result block captures the sum
      assign acc_out = sum;
    end else begin : g_reg
      acc_t acc_q;

      // Partial sum uses the coefficient current at this sample
      always_ff @(posedge tb_clk) begin
        if (!rst_n) begin
          acc_q <= '0;
        end else if (sample.valid) begin
          acc_q <= sum;
        end
      end

      assign acc_out = acc_q;
    end
  endgenerate

  // Chain stays clean once out of reset
  a_acc_known: assert property (@(posedge tb_clk) disable iff (!rst_n)
    !$isunknown(acc_out));

endmodule

//--- fir_result.sv
// FIR result stage
// Captures the top half of the filter sum from tap 0 on each new sample,
// flags overflow past 32 bits and reports busy while a sample is in flight

`timescale 1ns/1ps

module fir_result (
  input  logic           tb_clk,
  input  logic           rst_n,
  input  logic           sample_valid,
  input  fir_pkg::acc_t  acc,
  output fir_pkg::word_t result,
  output logic           busy,
  output logic           err
);
  import fir_pkg::*;

  word_t sum_hi;
  logic  sum_ovf;

  // ****************************************
  // Sum slicing
  // ****************************************
  // Bits 31:16 of the sum form the result
  assign sum_hi  = acc[PROD_W-1:DATA_W];

  // Any bit at or above 2^32 means overflow
  assign sum_ovf = |acc[ACC_W-1:PROD_W];

  // Result and err hold until the next sample
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      result <= '0;
      err    <= 1'b0;
    end else if (sample_valid) begin
      result <= sum_hi;
      err    <= sum_ovf;
    end
  end

  // Busy follows the registered sample strobe,
  // high only in the cycle before the result register loads
  assign busy = sample_valid;

  // Busy never stretches without a fresh sample
  a_busy_one_cycle: assert property (@(posedge tb_clk) disable iff (!rst_n)
    busy |=> (!busy || sample_valid));

endmodule

//--- ahb_fir_regs.sv
// AHB-Lite slave register block for the FIR filter
// Decodes the data phase, applies byte-lane writes to sample and coefficients,
// builds hrdata and hresp, and strobes each new sample into the taps

`timescale 1ns/1ps

module ahb_fir_regs (
  input  logic                  tb_clk,
  input  logic                  rst_n,
  input  fir_pkg::ahb_req_t     ahb_req,
  input  fir_pkg::word_t        hwdata,
  input  fir_pkg::word_t        result,
  input  logic                  busy,
  input  logic                  err,
  output fir_pkg::word_t        hrdata,
  output logic                  hresp,
  output fir_pkg::sample_beat_t sample,
  output fir_pkg::coef_bank_t   coefs
);
  import fir_pkg::*;

  localparam int IDX_W = $clog2(NUM_TAPS);

  ahb_req_t         dp_q;
  logic             accept;
  logic             dp_active;
  addr_t            waddr;
  addr_t            coef_off;
  logic [IDX_W-1:0] coef_idx;
  logic             is_status;
  logic             is_result;
  logic             is_sample;
  logic             is_coef;
  logic             misaligned;
  logic             bad_access;
  logic             wr_ok;
  logic             lane_lo;
  logic             lane_hi;
  logic             sample_wr;
  logic             coef_wr;

  // Merge the selected byte lanes of a write into a register
  function automatic word_t merge_lanes(input word_t cur, input word_t wd,
                                        input logic lo, input logic hi);
    word_t res;
    res = cur;
    if (lo) res[BYTE_W-1:0] = wd[BYTE_W-1:0];
    if (hi) res[DATA_W-1:BYTE_W] = wd[DATA_W-1:BYTE_W];
    return res;
  endfunction

  // ****************************************
  // Address phase capture
  // ****************************************
  assign accept = ahb_req.hsel && (ahb_req.htrans != HTRANS_IDLE);

  // Idle cycles leave an empty data phase behind
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      dp_q <= '0;
    end else begin
      dp_q <= accept ? ahb_req : '0;
    end
  end

  assign dp_active = dp_q.hsel && (dp_q.htrans != HTRANS_IDLE);

  // ****************************************
  // Data phase decode
  // ****************************************
  // Halfword-aligned register address
  assign waddr    = {dp_q.haddr[ADDR_W-1:1], 1'b0};
  assign coef_off = addr_t'(waddr - ADDR_COEF_BASE);
  assign coef_idx = coef_off[IDX_W:1];

  assign is_status = (waddr == ADDR_STATUS);
  assign is_result = (waddr == ADDR_RESULT);
  assign is_sample = (waddr == ADDR_SAMPLE);
  assign is_coef   = (waddr >= ADDR_COEF_BASE) && (waddr < ADDR_COEF_END);

  assign misaligned = (dp_q.hsize == HSIZE_HALF) && dp_q.haddr[0];

  // Unmapped, misaligned, or a write to a read-only register
  assign bad_access = dp_active &&
                      (misaligned ||
                       !(is_status || is_result || is_sample || is_coef) ||
                       (dp_q.hwrite && (is_status || is_result)));
  assign hresp      = bad_access;

  assign wr_ok     = dp_active && dp_q.hwrite && !bad_access;
  assign sample_wr = wr_ok && is_sample;
  assign coef_wr   = wr_ok && is_coef;

  // Byte at even address hits the low lane, odd the high lane
  assign lane_lo = (dp_q.hsize == HSIZE_HALF) || !dp_q.haddr[0];
  assign lane_hi = (dp_q.hsize == HSIZE_HALF) || dp_q.haddr[0];

  // ****************************************
  // Sample and coefficient registers
  // ****************************************
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      sample <= '0;
      coefs  <= '0;
    end else begin
      // One-cycle strobe per accepted sample write
      sample.valid <= sample_wr;
      if (sample_wr) begin
        sample.data <= merge_lanes(sample.data, hwdata, lane_lo, lane_hi);
      end
      if (coef_wr) begin
        coefs[coef_idx] <= merge_lanes(coefs[coef_idx], hwdata, lane_lo, lane_hi);
      end
    end
  end

  // Read mux, live register contents so a read after a write sees new data
  always_comb begin
    hrdata = '0;
    if (dp_active && !dp_q.hwrite && !bad_access) begin
      if (is_status) begin
        hrdata[STATUS_BUSY_BIT] = busy;
        hrdata[STATUS_ERR_BIT]  = err;
      end else if (is_result) begin
        hrdata = result;
      end else if (is_sample) begin
        hrdata = sample.data;
      end else begin
        hrdata = coefs[coef_idx];
      end
    end
  end

  // Error response only in the data phase of an accepted transfer
  a_hresp_after_accept: assert property (@(posedge tb_clk) disable iff (!rst_n)
    hresp |-> $past(accept));

  // Back-to-back strobes need back-to-back sample writes
  a_valid_needs_writes: assert property (@(posedge tb_clk) disable iff (!rst_n)
    (sample.valid && $past(sample.valid)) |-> ($past(sample_wr) && $past(sample_wr, 2)));

endmodule

//--- ahb_fir_top.sv
// AHB-Lite FIR filter top level
// Joins the register block, the chain of transposed tap stages and the
// result stage

`timescale 1ns/1ps

module ahb_fir_top (
  input  logic              tb_clk,
  input  logic              rst_n,
  input  fir_pkg::ahb_req_t ahb_req,
  input  fir_pkg::word_t    hwdata,
  output fir_pkg::word_t    hrdata,
  output logic              hresp
);
  import fir_pkg::*;

  sample_beat_t sample;
  coef_bank_t   coefs;
  word_t        result;
  logic         busy;
  logic         err;

  // Partial-sum chain, entry k is the output of tap k
  acc_t         acc_chain [NUM_TAPS+1];

  // Nothing feeds the last tap
  assign acc_chain[NUM_TAPS] = '0;

  // ****************************************
  // Bus slave and registers
  // ****************************************
  ahb_fir_regs u_regs (
    .tb_clk (tb_clk),
    .rst_n  (rst_n),
    .ahb_req(ahb_req),
    .hwdata (hwdata),
    .result (result),
    .busy   (busy),
    .err    (err),
    .hrdata (hrdata),
    .hresp  (hresp),
    .sample (sample),
    .coefs  (coefs)
  );

  // ****************************************
  // Tap stages, tap 0 drives the result
  // ****************************************
  for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
    fir_tap #(
      .COMB_OUT(k == 0)
    ) u_tap (
      .tb_clk (tb_clk),
      .rst_n  (rst_n),
      .sample (sample),
      .coef   (coefs[k]),
      .acc_in (acc_chain[k+1]),
      .acc_out(acc_chain[k])
    );
  end

  fir_result u_result (
    .tb_clk      (tb_clk),
    .rst_n       (rst_n),
    .sample_valid(sample.valid),
    .acc         (acc_chain[0]),
    .result      (result),
    .busy        (busy),
    .err         (err)
  );

endmodule

//--- tb_ahb_tasks.svh
// AHB-Lite master tasks for the FIR testbench
// Pipelined transfers with data-phase capture, and the random number source

`ifndef TB_AHB_TASKS_SVH
`define TB_AHB_TASKS_SVH

// LCG step, the common C library constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1103515245 + 32'd12345;
endfunction

// Upper half of the state has the better bits
task automatic next_random(output word_t value);
  lcg_state = lcg_next(lcg_state);
  value = lcg_state[31:16];
endtask

function automatic ahb_req_t make_req(input addr_t addr, input logic size, input logic write);
  ahb_req_t req;
  req.hsel   = 1'b1;
  req.htrans = HTRANS_NONSEQ;
  req.haddr  = addr;
  req.hsize  = size;
  req.hwrite = write;
  return req;
endfunction

// ****************************************
// Transfers
// ****************************************
// Each address phase overlaps the data phase of the transfer before it
task automatic run_burst(input int n);
  for (int i = 0; i <= n; i++) begin
    @(posedge tb_clk);
    #DRIVE_DLY;
    if (i < n) ahb_req = burst_req[i];
    else ahb_req = '0;
    if (i > 0) begin
      hwdata = burst_wdata[i-1];
      // Data phase outputs settled well before the next edge
      @(negedge tb_clk);
      burst_rdata[i-1] = hrdata;
      burst_resp[i-1]  = hresp;
    end
  end
endtask

task automatic write_reg(input addr_t addr, input logic size, input word_t data,
                         output logic resp);
  burst_req[0]   = make_req(addr, size, 1'b1);
  burst_wdata[0] = data;
  run_burst(1);
  resp = burst_resp[0];
endtask

// Halfword read
task automatic read_reg(input addr_t addr, output word_t data, output logic resp);
  burst_req[0]   = make_req(addr, HSIZE_HALF, 1'b0);
  burst_wdata[0] = '0;
  run_burst(1);
  data = burst_rdata[0];
  resp = burst_resp[0];
endtask

task automatic idle_cycles(input int n);
  repeat (n) @(posedge tb_clk);
endtask

`endif

//--- tb_ahb_fir.sv
// Testbench for the AHB-Lite FIR filter
// Runs reset, readback, error, filtering, pipelining and busy tests over the bus
// and compares against a reference model of the filter rule

`timescale 1ns/1ps

module tb_ahb_fir;
  import fir_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int RST_CYCLES = 8;
  localparam int IDLE_GAP   = 4;
  localparam int NUM_RANDOM = 8;
  localparam int NUM_LARGE  = 4;
  // Rough cycle length of each test, filtering dominates
  localparam int TEST_CYCLES = 40 + 60 + 50 + 260 + 30 + 30;
  localparam int WATCHDOG_NS = 2 * (RST_CYCLES + TEST_CYCLES) * CLK_PERIOD;

  logic       tb_clk = 1'b0;
  logic       rst_n;
  ahb_req_t   ahb_req;
  word_t      hwdata;
  word_t      hrdata;
  logic       hresp;

  // Burst buffers for the bus tasks
  ahb_req_t    burst_req   [8];
  word_t       burst_wdata [8];
  word_t       burst_rdata [8];
  logic        burst_resp  [8];
  logic [31:0] lcg_state = 32'd53175;

  // Reference model state, newest sample at index 0
  word_t ref_hist [NUM_TAPS];
  word_t ref_coef [NUM_TAPS];
  // Sample then F0 to F3, as the bus should show them
  word_t shadow   [NUM_TAPS+1];

  // Pending checks for the comparing process
  string name_q [$];
  word_t exp_q  [$];
  word_t act_q  [$];
  string cur_name;
  word_t cur_exp;
  word_t cur_act;
  int    check_count   = 0;
  int    error_count   = 0;
  int    errors_before = 0;

  word_t rd;
  word_t rnd;
  logic  resp;

  ahb_fir_top UUT (
    .tb_clk (tb_clk),
    .rst_n  (rst_n),
    .ahb_req(ahb_req),
    .hwdata (hwdata),
    .hrdata (hrdata),
    .hresp  (hresp)
  );

  always #(CLK_PERIOD / 2) tb_clk = ~tb_clk;

  `include "tb_ahb_tasks.svh"

  // ****************************************
  // Reference model
  // ****************************************
  // Filter rule, returns {err, result}
  function automatic logic [DATA_W:0] ref_filter(input word_t hist [NUM_TAPS],
                                                 input word_t coef [NUM_TAPS]);
    logic [35:0] sum;
    sum = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      sum = sum + 36'(hist[k]) * 36'(coef[k]);
    end
    return {(sum[35:32] != 4'd0), sum[31:16]};
  endfunction

  task automatic record_sample(input word_t value);
    for (int k = NUM_TAPS - 1; k > 0; k--) ref_hist[k] = ref_hist[k-1];
    ref_hist[0] = value;
  endtask

  function automatic addr_t reg_addr(input int i);
    return addr_t'(ADDR_SAMPLE + 2 * i);
  endfunction

  task automatic queue_check(input string name, input word_t exp, input word_t act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  // Comparing process
  always @(negedge tb_clk) begin
    while (exp_q.size() > 0) begin
      cur_name = name_q.pop_front();
      cur_exp  = exp_q.pop_front();
      cur_act  = act_q.pop_front();
      check_count++;
      if (cur_exp !== cur_act) begin
        error_count++;
        $display("[ERROR] %s: expected 0x%04h, actual 0x%04h", cur_name, cur_exp, cur_act);
      end
    end
  end

  // Synchronous reset, model history and coefficients cleared too
  task automatic apply_reset();
    @(posedge tb_clk);
    #DRIVE_DLY;
    rst_n   = 1'b0;
    ahb_req = '0;
    hwdata  = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      ref_hist[k] = '0;
      ref_coef[k] = '0;
    end
    repeat (RST_CYCLES) @(posedge tb_clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
  endtask

  task automatic send_sample(input word_t value);
    logic wr_resp;
    write_reg(ADDR_SAMPLE, HSIZE_HALF, value, wr_resp);
    record_sample(value);
  endtask

  task automatic set_coef(input int k, input word_t value);
    logic wr_resp;
    write_reg(reg_addr(k + 1), HSIZE_HALF, value, wr_resp);
    ref_coef[k] = value;
  endtask

  // Result and status error bit against the model
  task automatic check_filter(input string name);
    logic [DATA_W:0] expv;
    word_t           exp_status;
    word_t           rd_val;
    logic            rd_resp;
    expv = ref_filter(ref_hist, ref_coef);
    read_reg(ADDR_RESULT, rd_val, rd_resp);
    queue_check(name, expv[DATA_W-1:0], rd_val);
    exp_status = '0;
    exp_status[STATUS_ERR_BIT] = expv[DATA_W];
    read_reg(ADDR_STATUS, rd_val, rd_resp);
    queue_check({name, "_status"}, exp_status, rd_val);
  endtask

  task automatic expect_error(input addr_t addr, input logic size, input logic write);
    burst_req[0]   = make_req(addr, size, write);
    burst_wdata[0] = 16'hFFFF;
    run_burst(1);
    queue_check("error_response", word_t'(1), word_t'(burst_resp[0]));
  endtask

  task automatic check_shadow(input string name);
    word_t rd_val;
    logic  rd_resp;
    for (int i = 0; i <= NUM_TAPS; i++) begin
      read_reg(reg_addr(i), rd_val, rd_resp);
      queue_check(name, shadow[i], rd_val);
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    idle_cycles(2);
    errs = error_count - errors_before;
    errors_before = error_count;
    if (errs == 0) $display("[TEST] %s: ok", name);
    else $display("[TEST] %s: %0d mismatches", name, errs);
  endtask

  // ****************************************
  // Test sequence
  // ****************************************
  initial begin
    rst_n   = 1'b0;
    ahb_req = '0;
    hwdata  = '0;
    apply_reset();

    // Status, result, sample and F0 to F3
    for (int a = 0; a < 14; a += 2) begin
      read_reg(addr_t'(a), rd, resp);
      queue_check("reset_values", '0, rd);
      queue_check("reset_hresp", '0, word_t'(resp));
    end
    end_test("reset_values");

    for (int i = 0; i <= NUM_TAPS; i++) begin
      next_random(rnd);
      write_reg(reg_addr(i), HSIZE_HALF, rnd, resp);
      shadow[i] = rnd;
    end
    check_shadow("readback");
    // Byte lanes on F1, the other lane of hwdata carries junk
    write_reg(reg_addr(2), HSIZE_BYTE, 16'h773C, resp);
    shadow[2][7:0] = 8'h3C;
    check_shadow("byte_even");
    write_reg(reg_addr(2) + 1, HSIZE_BYTE, 16'hE155, resp);
    shadow[2][15:8] = 8'hE1;
    check_shadow("byte_odd");
    // Read in the cycle right behind the write
    burst_req[0]   = make_req(ADDR_SAMPLE, HSIZE_HALF, 1'b1);
    burst_wdata[0] = 16'h5A69;
    burst_req[1]   = make_req(ADDR_SAMPLE, HSIZE_HALF, 1'b0);
    burst_wdata[1] = '0;
    run_burst(2);
    shadow[0] = 16'h5A69;
    queue_check("read_after_write", 16'h5A69, burst_rdata[1]);
    end_test("readback_byte_lanes");

    expect_error(ADDR_STATUS, HSIZE_HALF, 1'b1);
    expect_error(ADDR_RESULT, HSIZE_HALF, 1'b1);
    expect_error(addr_t'(14), HSIZE_HALF, 1'b1);
    expect_error(addr_t'(15), HSIZE_BYTE, 1'b1);
    expect_error(addr_t'(5), HSIZE_HALF, 1'b1);
    expect_error(addr_t'(5), HSIZE_HALF, 1'b0);
    check_shadow("error_no_change");
    end_test("error_responses");

    // Fresh history for the filter tests
    apply_reset();
    for (int k = 0; k < NUM_TAPS; k++) begin
      next_random(rnd);
      set_coef(k, rnd);
    end
    for (int n = 0; n < NUM_RANDOM; n++) begin
      next_random(rnd);
      send_sample(rnd);
      idle_cycles(IDLE_GAP);
      check_filter("filter_random");
    end
    // Large values overflow past 32 bits
    for (int k = 0; k < NUM_TAPS; k++) begin
      next_random(rnd);
      set_coef(k, rnd | 16'hF000);
    end
    // Zero samples flush partial sums built with the old coefficients
    for (int n = 0; n < NUM_TAPS - 1; n++) begin
      send_sample('0);
      idle_cycles(IDLE_GAP);
    end
    for (int n = 0; n < NUM_LARGE; n++) begin
      next_random(rnd);
      send_sample(rnd | 16'hF000);
      idle_cycles(IDLE_GAP);
      check_filter("filter_large");
    end
    end_test("filtering");

    for (int i = 0; i < NUM_TAPS; i++) begin
      next_random(rnd);
      burst_req[i]   = make_req(ADDR_SAMPLE, HSIZE_HALF, 1'b1);
      burst_wdata[i] = rnd;
      record_sample(rnd);
    end
    run_burst(NUM_TAPS);
    idle_cycles(IDLE_GAP);
    check_filter("pipelined_samples");
    end_test("pipelined_samples");

    // Status read right behind a sample write
    next_random(rnd);
    burst_req[0]   = make_req(ADDR_SAMPLE, HSIZE_HALF, 1'b1);
    burst_wdata[0] = rnd;
    burst_req[1]   = make_req(ADDR_STATUS, HSIZE_HALF, 1'b0);
    burst_wdata[1] = '0;
    run_burst(2);
    record_sample(rnd);
    queue_check("busy_high", word_t'(1), word_t'(burst_rdata[1][STATUS_BUSY_BIT]));
    idle_cycles(IDLE_GAP);
    read_reg(ADDR_STATUS, rd, resp);
    queue_check("busy_low", '0, word_t'(rd[STATUS_BUSY_BIT]));
    check_filter("busy_result");
    end_test("busy");

    $display("Done: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
fir_pkg.sv
fir_tap.sv
fir_result.sv
ahb_fir_regs.sv
ahb_fir_top.sv
tb_ahb_fir.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FIR testbench with Verilator, pass or fail taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_ahb_fir \
  -f filelist.f -o tb_ahb_fir \
  && ./obj_dir/tb_ahb_fir | tee sim.log \
  || { echo "Build or run of the simulation failed"; exit 1; }

grep -q "SIMULATION PASSED" sim.log \
  && echo "Run passed" \
  || { echo "Run failed, see sim.log"; exit 1; }
